// ==== include/dvi_macros.svh ====
// DVI video macros
// 640x480p60 raster periods from CEA-861D, counter and colour widths

`ifndef DVI_MACROS_SVH
`define DVI_MACROS_SVH

// --------------------------------------------------
// Horizontal periods, in pixels

`define DVI_H_ACTIVE 640
`define DVI_H_FRONT  16
`define DVI_H_SYNC   96
`define DVI_H_BACK   48

// --------------------------------------------------
// Vertical periods, in lines

`define DVI_V_ACTIVE 480
`define DVI_V_FRONT  10
`define DVI_V_SYNC   2
`define DVI_V_BACK   33

`define DVI_SYNC_POL 1'b0 // Both syncs negative

// --------------------------------------------------
// Widths

`define DVI_CTR_W   11 // Covers 800 pixels and 525 lines
`define DVI_COLOR_W 8

`endif

// ==== verilog/dvi_timing_pkg.sv ====
// DVI timing types
// Screen coordinates and raster phases shared by the timing path

package dvi_timing_pkg;

`include "dvi_macros.svh"

	// Screen coordinate or frame count
	typedef logic [`DVI_CTR_W-1:0] raster_ctr_t;

	// Phase order within a line or a frame
	// Encoding counts up so that phase + 1 is the next phase
	typedef enum logic [1:0] {
		PH_ACTIVE = 2'd0,
		PH_FRONT  = 2'd1,
		PH_SYNC   = 2'd2,
		PH_BACK   = 2'd3
	} raster_phase_e;

endpackage

// ==== verilog/tmds_pkg.sv ====
// TMDS symbol types
// Symbol views, running disparity and the four control codes

package tmds_pkg;

	// Data view of a symbol as the encoder builds it
	typedef struct packed {
		logic       invert;  // Bits 7:0 were inverted
		logic       use_xor; // 1 for XOR, 0 for XNOR
		logic [7:0] coded;
	} tmds_data_t;

	typedef union packed {
		logic [9:0] raw;     // Symbol as sent, bit 0 first
		tmds_data_t data;
	} tmds_word_u;

	// Ones minus zeros of all symbols sent so far
	typedef logic signed [4:0] disparity_t;

	// --------------------------------------------------
	// Control codes, indexed by {c1,c0}

	localparam logic [9:0] TMDS_CTRL_00 = 10'b1101010100;
	localparam logic [9:0] TMDS_CTRL_01 = 10'b0010101011;
	localparam logic [9:0] TMDS_CTRL_10 = 10'b0101010100;
	localparam logic [9:0] TMDS_CTRL_11 = 10'b1010101011;

	function automatic logic [9:0] tmds_ctrl_symbol(input logic [1:0] ctrl);
		case (ctrl)
			2'b00:   return TMDS_CTRL_00;
			2'b01:   return TMDS_CTRL_01;
			2'b10:   return TMDS_CTRL_10;
			default: return TMDS_CTRL_11;
		endcase
	endfunction

endpackage

// ==== verilog/dvi_timing_gen.sv ====
// DVI timing generator
// Horizontal and vertical raster counters with registered syncs and data enable

`timescale 1ns/100ps

`include "dvi_macros.svh"

module dvi_timing_gen (
	input  logic clk_dvi_pix,
	input  logic rst_n_dvi_pix,
	input  logic i_en,
	output logic o_de,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_rgb_rdy
);

	import dvi_timing_pkg::*;

	raster_ctr_t   h_ctr;   // Position within the current h phase
	raster_ctr_t   v_ctr;   // Line within the current v phase
	raster_phase_e h_phase;
	raster_phase_e v_phase;
	raster_ctr_t   h_len;   // Current phase length minus one
	raster_ctr_t   v_len;
	logic          h_last;
	logic          v_last;
	logic          pix_active;

	// --------------------------------------------------
	// Phase lengths

	always_comb begin
		case (h_phase)
			PH_ACTIVE: h_len = raster_ctr_t'(`DVI_H_ACTIVE - 1);
			PH_FRONT:  h_len = raster_ctr_t'(`DVI_H_FRONT - 1);
			PH_SYNC:   h_len = raster_ctr_t'(`DVI_H_SYNC - 1);
			default:   h_len = raster_ctr_t'(`DVI_H_BACK - 1);
		endcase
		case (v_phase)
			PH_ACTIVE: v_len = raster_ctr_t'(`DVI_V_ACTIVE - 1);
			PH_FRONT:  v_len = raster_ctr_t'(`DVI_V_FRONT - 1);
			PH_SYNC:   v_len = raster_ctr_t'(`DVI_V_SYNC - 1);
			default:   v_len = raster_ctr_t'(`DVI_V_BACK - 1);
		endcase
	end

	assign h_last = (h_ctr == h_len);
	assign v_last = (v_ctr == v_len);

	// --------------------------------------------------
	// Raster counters, held while disabled

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			h_ctr   <= '0;
			v_ctr   <= '0;
			h_phase <= PH_ACTIVE;
			v_phase <= PH_ACTIVE;
		end else if (i_en) begin
			if (h_last) begin
				h_ctr   <= '0;
				h_phase <= raster_phase_e'(h_phase + 2'd1);
				if (h_phase == PH_BACK) begin // End of line
					if (v_last) begin
						v_ctr   <= '0;
						v_phase <= raster_phase_e'(v_phase + 2'd1);
					end else begin
						v_ctr <= v_ctr + 1'b1;
					end
				end
			end else begin
				h_ctr <= h_ctr + 1'b1;
			end
		end
	end

	// Pixel request leads the registered de by one cycle
	assign pix_active = i_en && (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);
	assign o_rgb_rdy  = pix_active;

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_de    <= 1'b0;
			o_hsync <= ~`DVI_SYNC_POL;
			o_vsync <= ~`DVI_SYNC_POL;
		end else begin
			o_de    <= pix_active;
			o_hsync <= (i_en && h_phase == PH_SYNC) ? `DVI_SYNC_POL : ~`DVI_SYNC_POL;
			o_vsync <= (i_en && v_phase == PH_SYNC) ? `DVI_SYNC_POL : ~`DVI_SYNC_POL;
		end
	end

endmodule

// ==== verilog/test_pattern_gen.sv ====
// Test pattern generator
// Moving colour pattern from active pixel, line and frame counters

`timescale 1ns/100ps

`include "dvi_macros.svh"

module test_pattern_gen (
	input  logic                    clk_dvi_pix,
	input  logic                    rst_n_dvi_pix,
	input  logic                    i_rgb_rdy,
	output logic [`DVI_COLOR_W-1:0] o_red,
	output logic [`DVI_COLOR_W-1:0] o_green,
	output logic [`DVI_COLOR_W-1:0] o_blue
);

	import dvi_timing_pkg::*;

	raster_ctr_t h_pix;
	raster_ctr_t v_line;
	raster_ctr_t frame;
	raster_ctr_t red_sum;
	raster_ctr_t green_sum;

	// Active position only, porches never reach here
	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			h_pix  <= '0;
			v_line <= '0;
			frame  <= '0;
		end else if (i_rgb_rdy) begin
			if (h_pix == raster_ctr_t'(`DVI_H_ACTIVE - 1)) begin
				h_pix <= '0;
				if (v_line == raster_ctr_t'(`DVI_V_ACTIVE - 1)) begin
					v_line <= '0;
					frame  <= frame + 1'b1; // After last active pixel
				end else begin
					v_line <= v_line + 1'b1;
				end
			end else begin
				h_pix <= h_pix + 1'b1;
			end
		end
	end

	assign red_sum   = h_pix + frame;
	assign green_sum = v_line + frame;

	// Colours line up with the registered de
	always_ff @(posedge clk_dvi_pix) begin
		if (i_rgb_rdy) begin
			o_red   <= `DVI_COLOR_W'(red_sum << 2);
			o_green <= `DVI_COLOR_W'(green_sum << 2);
			o_blue  <= `DVI_COLOR_W'(frame);
		end
	end

endmodule

// ==== verilog/tmds_encoder.sv ====
// TMDS channel encoder
// 8b/10b DVI coding with running disparity, control codes during blanking

`timescale 1ns/100ps

module tmds_encoder (
	input  logic                clk_dvi_pix,
	input  logic                rst_n_dvi_pix,
	input  logic [7:0]          i_data,
	input  logic [1:0]          i_ctrl,
	input  logic                i_de,
	output tmds_pkg::tmds_word_u o_symbol
);

	import tmds_pkg::*;

	logic [3:0] n1_d;      // Ones in the input byte
	logic [3:0] n1_q;      // Ones after XOR/XNOR
	logic       use_xnor;
	logic [8:0] q_m;
	disparity_t q_bal;     // Ones minus zeros of q_m[7:0]
	disparity_t disparity;
	disparity_t disp_next;
	tmds_word_u word;

	// --------------------------------------------------
	// Transition minimising stage

	always_comb begin
		n1_d = '0;
		for (int i = 0; i < 8; i++)
			n1_d = n1_d + 4'(i_data[i]);
		use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !i_data[0]);

		q_m[0] = i_data[0];
		for (int i = 1; i < 8; i++)
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
		q_m[8] = ~use_xnor;

		n1_q = '0;
		for (int i = 0; i < 8; i++)
			n1_q = n1_q + 4'(q_m[i]);
		q_bal = disparity_t'(2 * int'(n1_q) - 8);
	end

	// --------------------------------------------------
	// DC balancing stage

	always_comb begin
		word.data.use_xor = q_m[8];
		if (disparity == 0 || q_bal == 0) begin
			word.data.invert = ~q_m[8];
			word.data.coded  = q_m[8] ? q_m[7:0] : ~q_m[7:0];
			disp_next        = q_m[8] ? disparity + q_bal : disparity - q_bal;
		end else if ((disparity > 0 && q_bal > 0) || (disparity < 0 && q_bal < 0)) begin
			word.data.invert = 1'b1; // Pull back towards zero
			word.data.coded  = ~q_m[7:0];
			disp_next        = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - q_bal;
		end else begin
			word.data.invert = 1'b0;
			word.data.coded  = q_m[7:0];
			disp_next        = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + q_bal;
		end
	end

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_symbol.raw <= TMDS_CTRL_11; // Inactive negative syncs
			disparity    <= '0;
		end else if (i_de) begin
			o_symbol  <= word;
			disparity <= disp_next;
		end else begin
			o_symbol.raw <= tmds_ctrl_symbol(i_ctrl);
			disparity    <= '0; // Blanking restarts the balance
		end
	end

endmodule

// ==== verilog/dvi_tx_top.sv ====
// DVI transmitter top level
// Timing, test pattern and three TMDS encoders producing parallel symbols

`timescale 1ns/100ps

`include "dvi_macros.svh"

module dvi_tx_top (
	input  logic                 clk_dvi_pix,
	input  logic                 rst_n_dvi_pix,
	input  logic                 i_en,
	output tmds_pkg::tmds_word_u o_tmds0,
	output tmds_pkg::tmds_word_u o_tmds1,
	output tmds_pkg::tmds_word_u o_tmds2
);

	logic                    de;
	logic                    hsync;
	logic                    vsync;
	logic                    rgb_rdy;
	logic [`DVI_COLOR_W-1:0] red;
	logic [`DVI_COLOR_W-1:0] green;
	logic [`DVI_COLOR_W-1:0] blue;

	dvi_timing_gen u_timing (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_en          (i_en),
		.o_de          (de),
		.o_hsync       (hsync),
		.o_vsync       (vsync),
		.o_rgb_rdy     (rgb_rdy)
	);

	test_pattern_gen u_pattern (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_rgb_rdy     (rgb_rdy),
		.o_red         (red),
		.o_green       (green),
		.o_blue        (blue)
	);

	// --------------------------------------------------
	// Encoders, syncs ride on channel 0 only

	tmds_encoder u_enc0 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (blue),
		.i_ctrl        ({vsync, hsync}),
		.i_de          (de),
		.o_symbol      (o_tmds0)
	);

	tmds_encoder u_enc1 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (green),
		.i_ctrl        (2'b00),
		.i_de          (de),
		.o_symbol      (o_tmds1)
	);

	tmds_encoder u_enc2 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (red),
		.i_ctrl        (2'b00),
		.i_de          (de),
		.o_symbol      (o_tmds2)
	);

endmodule

// ==== dv/dvi_tx_assert.sv ====
// TMDS encoder assertions
// Disparity bounds and control code placement, bound into every encoder

`timescale 1ns/100ps

module dvi_tx_assert (
	input logic                 clk_dvi_pix,
	input logic                 rst_n_dvi_pix,
	input logic                 i_de,
	input tmds_pkg::tmds_word_u i_symbol,
	input tmds_pkg::disparity_t i_disparity
);

	import tmds_pkg::*;

	function automatic logic ctrl_code_seen(input logic [9:0] raw);
		return raw == TMDS_CTRL_00 || raw == TMDS_CTRL_01 ||
			raw == TMDS_CTRL_10 || raw == TMDS_CTRL_11;
	endfunction

	// Running disparity even and bounded
	disparity_ok: assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		!i_disparity[0] && i_disparity >= -5'sd8 && i_disparity <= 5'sd8)
		else $error("disparity out of range");

	blank_is_ctrl: assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		!i_de |=> ctrl_code_seen(i_symbol.raw))
		else $error("blanking symbol is not a control code");

	data_not_ctrl: assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		i_de |=> !ctrl_code_seen(i_symbol.raw))
		else $error("data symbol looks like a control code");

endmodule

bind tmds_encoder dvi_tx_assert u_assert (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_de          (i_de),
	.i_symbol      (o_symbol),
	.i_disparity   (disparity)
);

// ==== dv/dvi_tx_tb.sv ====
// DVI transmitter testbench
// Decodes the three TMDS channels and checks raster structure and test pattern

`timescale 1ns/100ps

`include "dvi_macros.svh"

module dvi_tx_tb;

	import dvi_timing_pkg::*;
	import tmds_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int H_TOTAL = `DVI_H_ACTIVE + `DVI_H_FRONT + `DVI_H_SYNC + `DVI_H_BACK;
	localparam int V_TOTAL = `DVI_V_ACTIVE + `DVI_V_FRONT + `DVI_V_SYNC + `DVI_V_BACK;
	localparam int H_SYNC_START = `DVI_H_ACTIVE + `DVI_H_FRONT;
	localparam int V_SYNC_START = `DVI_V_ACTIVE + `DVI_V_FRONT;
	localparam int N_ROWS = 8;

	logic       clk_dvi_pix;
	logic       rst_n_dvi_pix;
	logic       i_en;
	tmds_word_u o_tmds0;
	tmds_word_u o_tmds1;
	tmds_word_u o_tmds2;

	// Stimulus table
	string row_name [N_ROWS];
	logic  row_en [N_ROWS];
	int    row_cycles [N_ROWS];
	logic  row_sample [N_ROWS];
	int    row_frame [N_ROWS];
	int    row_line [N_ROWS];
	int    row_col [N_ROWS];

	// Decoder state
	logic [1:0]             en_hist;
	logic                   after_rst;
	logic                   aligned;
	logic                   prev_vs;
	int                     col, line, frame;
	int                     data_cnt, hs_cnt, act_lines, vs_lines;
	int                     last_frame, last_line, last_col;
	logic [`DVI_COLOR_W-1:0] last_red, last_green, last_blue;
	event                   sym_seen;

	dvi_tx_top DUT (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_en          (i_en),
		.o_tmds0       (o_tmds0),
		.o_tmds1       (o_tmds1),
		.o_tmds2       (o_tmds2)
	);

	initial begin
		clk_dvi_pix = 1'b0;
		forever #(CLK_PERIOD / 2) clk_dvi_pix = ~clk_dvi_pix;
	end

	// --------------------------------------------------
	// Reference rules and TMDS decoding

	function automatic logic [`DVI_COLOR_W-1:0] exp_red(input int h, input int f);
		return `DVI_COLOR_W'((h + f) << 2);
	endfunction

	function automatic logic [`DVI_COLOR_W-1:0] exp_green(input int v, input int f);
		return `DVI_COLOR_W'((v + f) << 2);
	endfunction

	function automatic logic [7:0] decode_byte(input tmds_word_u w);
		logic [7:0] d;
		logic [7:0] b;
		d = w.data.invert ? ~w.data.coded : w.data.coded;
		b[0] = d[0];
		for (int i = 1; i < 8; i++)
			b[i] = w.data.use_xor ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		return b;
	endfunction

	function automatic logic is_ctrl(input logic [9:0] raw);
		return raw == TMDS_CTRL_00 || raw == TMDS_CTRL_01 ||
			raw == TMDS_CTRL_10 || raw == TMDS_CTRL_11;
	endfunction

	function automatic logic [1:0] ctrl_bits(input logic [9:0] raw);
		if (raw == TMDS_CTRL_01) return 2'b01;
		if (raw == TMDS_CTRL_10) return 2'b10;
		if (raw == TMDS_CTRL_11) return 2'b11;
		return 2'b00;
	endfunction

	function automatic logic [9:0] ctrl_code(input logic [1:0] c);
		if (c == 2'b01) return TMDS_CTRL_01;
		if (c == 2'b10) return TMDS_CTRL_10;
		if (c == 2'b11) return TMDS_CTRL_11;
		return TMDS_CTRL_00;
	endfunction

	// --------------------------------------------------
	// Compare tasks

	task automatic check_symbol(input string name, input tmds_word_u exp, input tmds_word_u act);
		if (act.raw !== exp.raw) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp.raw, act.raw);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_color(input string name, input logic [`DVI_COLOR_W-1:0] exp,
		input logic [`DVI_COLOR_W-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_count(input string name, input raster_ctr_t exp, input raster_ctr_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic fail_plain(input string what);
		$display("%s at frame %0d line %0d column %0d", what, frame, line, col);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// --------------------------------------------------
	// Stream monitor, sampled away from the output edge

	always @(negedge clk_dvi_pix) begin
		logic       valid;
		logic       exp_de;
		logic       exp_hs;
		logic       exp_vs;
		logic       vs;
		logic [1:0] cb;
		if (!rst_n_dvi_pix) begin
			after_rst = 1'b1;
			en_hist   = 2'b00;
		end else if (after_rst) begin
			check_symbol("reset_ch0", TMDS_CTRL_11, o_tmds0);
			check_symbol("reset_ch1", TMDS_CTRL_11, o_tmds1);
			check_symbol("reset_ch2", TMDS_CTRL_11, o_tmds2);
			after_rst = 1'b0;
			en_hist   = {en_hist[0], i_en};
		end else begin
			valid   = en_hist[1]; // Enable seen two cycles earlier
			en_hist = {en_hist[0], i_en};
			if (!valid) begin
				check_symbol("pause_ch0", TMDS_CTRL_11, o_tmds0);
				check_symbol("pause_ch1", TMDS_CTRL_00, o_tmds1);
				check_symbol("pause_ch2", TMDS_CTRL_00, o_tmds2);
			end else begin
				exp_de = (col < `DVI_H_ACTIVE) && (line < `DVI_V_ACTIVE);
				if (exp_de == is_ctrl(o_tmds0.raw))
					fail_plain("Channel 0 symbol type does not fit the raster position");
				if (exp_de) begin
					check_color($sformatf("red f%0d l%0d c%0d", frame, line, col),
						exp_red(col, frame), decode_byte(o_tmds2));
					check_color($sformatf("green f%0d l%0d c%0d", frame, line, col),
						exp_green(line, frame), decode_byte(o_tmds1));
					check_color($sformatf("blue f%0d l%0d c%0d", frame, line, col),
						`DVI_COLOR_W'(frame), decode_byte(o_tmds0));
					last_red   = decode_byte(o_tmds2);
					last_green = decode_byte(o_tmds1);
					last_blue  = decode_byte(o_tmds0);
					data_cnt++;
				end else begin
					exp_hs = (col >= H_SYNC_START && col < H_SYNC_START + `DVI_H_SYNC) ?
						`DVI_SYNC_POL : ~`DVI_SYNC_POL;
					exp_vs = (line >= V_SYNC_START && line < V_SYNC_START + `DVI_V_SYNC) ?
						`DVI_SYNC_POL : ~`DVI_SYNC_POL;
					check_symbol($sformatf("blank_ch0 l%0d c%0d", line, col),
						ctrl_code({exp_vs, exp_hs}), o_tmds0);
					check_symbol("blank_ch1", TMDS_CTRL_00, o_tmds1);
					check_symbol("blank_ch2", TMDS_CTRL_00, o_tmds2);
					cb = ctrl_bits(o_tmds0.raw);
					vs = cb[1];
					if (!cb[0])
						hs_cnt++;
					if (!vs && prev_vs && !aligned) begin // First vsync fall
						if (line != V_SYNC_START || col != 0)
							fail_plain("Decoded vsync fell at the wrong place, stream lost alignment");
						aligned = 1'b1;
					end
					prev_vs = vs;
					if (col == 0 && !vs)
						vs_lines++;
				end
				last_frame = frame;
				last_line  = line;
				last_col   = col;
				-> sym_seen;
				if (col == H_TOTAL - 1) begin
					// Blank lines carry no data symbols
					check_count($sformatf("line_data l%0d", line),
						raster_ctr_t'((line < `DVI_V_ACTIVE) ? `DVI_H_ACTIVE : 0),
						raster_ctr_t'(data_cnt));
					check_count($sformatf("hsync_width l%0d", line),
						raster_ctr_t'(`DVI_H_SYNC), raster_ctr_t'(hs_cnt));
					if (data_cnt > 0)
						act_lines++;
					data_cnt = 0;
					hs_cnt   = 0;
					col      = 0;
					if (line == V_TOTAL - 1) begin
						check_count("active_lines", raster_ctr_t'(`DVI_V_ACTIVE),
							raster_ctr_t'(act_lines));
						check_count("vsync_lines", raster_ctr_t'(`DVI_V_SYNC),
							raster_ctr_t'(vs_lines));
						act_lines = 0;
						vs_lines  = 0;
						line      = 0;
						frame++;
					end else begin
						line++;
					end
				end else begin
					col++;
				end
			end
		end
	end

	// --------------------------------------------------
	// Table and stimulus

	task automatic set_row(input int r, input string name, input logic en, input int cycles,
		input logic sample, input int f, input int l, input int c);
		row_name[r]   = name;
		row_en[r]     = en;
		row_cycles[r] = cycles;
		row_sample[r] = sample;
		row_frame[r]  = f;
		row_line[r]   = l;
		row_col[r]    = c;
	endtask

	initial begin
		i_en          = 1'b0;
		rst_n_dvi_pix = 1'b0;
		after_rst = 1'b0;
		aligned   = 1'b0;
		prev_vs   = 1'b1;
		en_hist   = 2'b00;
		col = 0;
		line = 0;
		frame = 0;
		data_cnt = 0;
		hs_cnt = 0;
		act_lines = 0;
		vs_lines = 0;
		last_frame = -1;
		last_line = -1;
		last_col = -1;
		set_row(0, "f0_origin", 1'b1, 1, 1'b1, 0, 0, 0);
		set_row(1, "f0_mid", 1'b1, 1, 1'b1, 0, 100, 200);
		set_row(2, "pause", 1'b0, 3000, 1'b0, 0, 0, 0);
		set_row(3, "f0_resume", 1'b1, 1, 1'b1, 0, 100, 210);
		set_row(4, "f0_last", 1'b1, 1, 1'b1, 0, 479, 639);
		set_row(5, "f1_first", 1'b1, 1, 1'b1, 1, 0, 0);
		set_row(6, "f1_mid", 1'b1, 1, 1'b1, 1, 300, 123);
		set_row(7, "f1_last", 1'b1, 1, 1'b1, 1, 479, 639);

		repeat (5) @(posedge clk_dvi_pix);
		rst_n_dvi_pix <= 1'b1;

		for (int r = 0; r < N_ROWS; r++) begin
			@(posedge clk_dvi_pix);
			i_en <= row_en[r];
			repeat (row_cycles[r] - 1) @(posedge clk_dvi_pix);
			if (row_sample[r]) begin
				while (!(last_frame == row_frame[r] && last_line == row_line[r] &&
					last_col == row_col[r]))
					@(sym_seen);
				check_color({row_name[r], "_red"},
					exp_red(row_col[r], row_frame[r]), last_red);
				check_color({row_name[r], "_green"},
					exp_green(row_line[r], row_frame[r]), last_green);
				check_color({row_name[r], "_blue"}, `DVI_COLOR_W'(row_frame[r]), last_blue);
			end
		end

		if (aligned) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Decoded vsync never fell, the frame structure was not seen");
			$display("TEST FAIL");
			$fatal(1, "no vsync");
		end
	end

	// Watchdog sized from two frames plus the table cycles
	initial begin
		longint limit;
		limit = 2 * H_TOTAL * V_TOTAL + 20000;
		for (int r = 0; r < N_ROWS; r++)
			limit += row_cycles[r];
		#(limit * CLK_PERIOD);
		$display("Watchdog expired before the table finished");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

endmodule

// ==== project.f ====
+incdir+include
verilog/dvi_timing_pkg.sv
verilog/tmds_pkg.sv
verilog/dvi_timing_gen.sv
verilog/test_pattern_gen.sv
verilog/tmds_encoder.sv
verilog/dvi_tx_top.sv
dv/dvi_tx_assert.sv
dv/dvi_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DVI transmitter simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f project.f \
	--top-module dvi_tx_tb \
	-o sim_dvi_tx

./obj_dir/sim_dvi_tx > sim.log 2>&1 || true
cat sim.log

grep -q "^TEST PASS$" sim.log
echo "Simulation passed"
